//--- run.sh
#!/usr/bin/env bash
# Build the MMC5 testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timescale 1ns/1ps -f sim.f --top-module tb_mmc5 -o tb_mmc5 \
	&& ./obj_dir/tb_mmc5 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qx "Test completed successfully" sim.log && exit 0 || exit 1

//--- sim.f
+incdir+src
src/mmc5_cpu_pkg.sv
src/mmc5_ppu_pkg.sv
src/mmc5_regs.sv
src/prg_window.sv
src/prg_map.sv
src/chr_map.sv
src/scanline_irq.sv
src/exram.sv
src/mmc5_top.sv
sim/tb_mmc5.sv

//--- sim/tb_mmc5.sv
// Self-checking testbench for the MMC5 mapper top level, run through the file list in the root
`timescale 1ns/1ps
`default_nettype none
`include "mmc5_params.svh"

module tb_mmc5;
	import mmc5_cpu_pkg::*;
	import mmc5_ppu_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        ce;
	logic [15:0] prg_ain;
	logic [7:0]  prg_din;
	logic        prg_read;
	logic        prg_write;
	logic [13:0] chr_ain;
	logic        ppu_ce;
	logic        ppu_in_frame;
	scanline_t   ppu_scanline;
	prg_addr_t   prg_aout;
	logic        prg_allow;
	logic [7:0]  prg_dout;
	chr_addr_t   chr_aout;
	logic        irq;

	integer          seed;
	prg_bank_t [3:0] prg_banks;  // Shadow of $5114 to $5117
	logic [2:0]      ram_bank;   // Shadow of $5113
	chr_bank_t [7:0] chr_banks;  // Shadow of set A, upper bits included

	mmc5_top uut (
		.clk(clk), .rst_n(rst_n), .ce(ce), .prg_ain(prg_ain), .prg_din(prg_din),
		.prg_read(prg_read), .prg_write(prg_write), .chr_ain(chr_ain), .ppu_ce(ppu_ce),
		.ppu_in_frame(ppu_in_frame), .ppu_scanline(ppu_scanline), .prg_aout(prg_aout),
		.prg_allow(prg_allow), .prg_dout(prg_dout), .chr_aout(chr_aout), .irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	function automatic logic [15:0] reg_addr(input logic [9:0] offset);
		return {`MMC5_REG_BASE, offset};
	endfunction

	// Expected PRG address from the window and mapping rules
	function automatic prg_addr_t exp_prg_addr(input logic [15:0] addr, input prg_mode_t mode,
			input prg_bank_t [3:0] banks, input logic [2:0] rbank);
		logic [1:0] w;    // 8 kB window at $8000 and up
		prg_bank_t  top;
		prg_bank_t  b;
		w   = addr[14:13];
		top = {1'b1, banks[3][6:0]};  // Bank 3 is always ROM
		case (mode)
			2'd0:    b = {top[7:2], w};
			2'd1:    b = w[1] ? {top[7:1], w[0]} : {banks[1][7:1], w[0]};
			2'd2:    b = w[1] ? (w[0] ? top : banks[2]) : {banks[1][7:1], w[0]};
			default: b = (w == 2'd3) ? top : banks[w];
		endcase
		if (!addr[15])
			b = {5'd0, rbank};  // Save RAM window
		if (b[7])
			return {2'b00, b[6:0], addr[12:0]};
		return {`MMC5_RAM_BASE_HI, b[2:0], addr[12:0]};
	endfunction

	// Expected CHR address, page size 8 kB down to 1 kB
	function automatic chr_addr_t exp_chr_addr(input logic [13:0] ain, input chr_mode_t mode,
			input chr_bank_t [7:0] banks);
		logic [2:0] mask;   // Address bits inside a page larger than 1 kB
		logic [1:0] shift;  // Log2 of the page size in kB
		chr_bank_t  page;
		mask  = 3'b111 >> mode;
		shift = 2'd3 - mode;
		page  = (banks[ain[12:10] | mask] << shift) | {7'd0, ain[12:10] & mask};
		return {2'b10, page, ain[9:0]};
	endfunction

	function automatic logic [15:0] exp_product(input logic [7:0] a, input logic [7:0] b);
		return {8'd0, a} * {8'd0, b};
	endfunction

	task automatic check_prg(input string name, input prg_addr_t exp, input prg_addr_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_chr(input string name, input chr_addr_t exp, input chr_addr_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// One CPU write cycle with ce
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		prg_ain   = addr;
		prg_din   = data;
		prg_read  = 1'b0;
		prg_write = 1'b1;
		ce        = 1'b1;
		@(posedge clk);
		#1;
		prg_write = 1'b0;
		ce        = 1'b0;
	endtask

	// Address a cycle ahead so registered ExRAM data has settled, ce on the last cycle
	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk);
		#1;
		prg_ain   = addr;
		prg_write = 1'b0;
		prg_read  = 1'b1;
		@(posedge clk);
		#1;
		ce = 1'b1;
		@(negedge clk);
		data = prg_dout;
		@(posedge clk);
		#1;
		ce       = 1'b0;
		prg_read = 1'b0;
	endtask

	task automatic drive_prg(input logic [15:0] addr, input logic wr);
		@(posedge clk);
		#1;
		prg_ain   = addr;
		prg_write = wr;  // No ce, so nothing is written
		@(negedge clk);
	endtask

	task automatic check_allow(input string name, input logic [15:0] addr, input logic wr,
			input logic exp);
		drive_prg(addr, wr);
		check_byte(name, {7'd0, exp}, {7'd0, prg_allow});
	endtask

	task automatic drive_chr(input logic [13:0] addr);
		@(posedge clk);
		#1;
		chr_ain = addr;
		@(negedge clk);
	endtask

	// One PPU strobe on a given line, sampled after the edge
	task automatic ppu_step(input scanline_t line, input logic in_frame);
		@(posedge clk);
		#1;
		ppu_scanline = line;
		ppu_in_frame = in_frame;
		ppu_ce       = 1'b1;
		@(posedge clk);
		#1;
		ppu_ce = 1'b0;
		@(negedge clk);
	endtask

	initial begin : stimulus
		logic [31:0] r;
		logic [15:0] addr;
		logic [15:0] p;
		logic [7:0]  data;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  v;
		logic [9:0]  n;
		logic [1:0]  upper;
		logic [7:0]  t;
		int          rise;
		seed         = 42;
		rst_n        = 1'b0;
		ce           = 1'b0;
		prg_ain      = 16'h0000;
		prg_din      = 8'h00;
		prg_read     = 1'b0;
		prg_write    = 1'b0;
		chr_ain      = 14'h0000;
		ppu_ce       = 1'b0;
		ppu_in_frame = 1'b0;
		ppu_scanline = '0;
		prg_banks    = '0;
		prg_banks[3] = `MMC5_RESET_PRG_BANK3;
		ram_bank     = 3'd0;
		chr_banks    = '0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Reset state, last ROM bank at $E000 and no IRQ pending
		r    = $random(seed);
		addr = {3'b111, r[12:0]};
		drive_prg(addr, 1'b0);
		check_prg("reset_e000", exp_prg_addr(addr, 2'd3, prg_banks, ram_bank), prg_aout);
		cpu_read(reg_addr(`MMC5_REG_IRQ_STATUS), data);
		check_byte("reset_status", 8'h3F, data);

		// PRG mapping in every mode
		for (int m = 0; m < 4; m++) begin
			cpu_write(reg_addr(`MMC5_REG_PRG_MODE), {6'd0, m[1:0]});
			for (int i = 0; i < 4; i++) begin
				r = $random(seed);
				prg_banks[i] = {i[0] ^ m[0], r[6:0]};  // RAM and ROM mixed per mode
				cpu_write(reg_addr(`MMC5_REG_PRG_BANK0 + 10'(i)), prg_banks[i]);
			end
			r        = $random(seed);
			ram_bank = r[2:0];
			cpu_write(reg_addr(`MMC5_REG_PRG_RAM), {5'd0, ram_bank});
			for (int k = 0; k < 8; k++) begin
				r    = $random(seed);
				addr = r[15:0];
				if (addr[15:13] < 3'd3)
					addr[15] = 1'b1;  // Stay at $6000 and up
				drive_prg(addr, 1'b0);
				check_prg($sformatf("prg_mode%0d_addr%h", m, addr),
					exp_prg_addr(addr, m[1:0], prg_banks, ram_bank), prg_aout);
			end
		end

		// Write protection
		cpu_write(reg_addr(`MMC5_REG_PRG_MODE), 8'd3);
		cpu_write(reg_addr(`MMC5_REG_PRG_BANK0), 8'h05);          // $8000 RAM
		cpu_write(reg_addr(`MMC5_REG_PRG_BANK0 + 10'd1), 8'h85);  // $A000 ROM
		check_allow("locked_ram_wr", 16'h8000, 1'b1, 1'b0);
		check_allow("locked_sram_wr", 16'h6000, 1'b1, 1'b0);
		cpu_write(reg_addr(`MMC5_REG_PROTECT1), 8'h02);
		check_allow("half_unlocked_wr", 16'h8000, 1'b1, 1'b0);
		cpu_write(reg_addr(`MMC5_REG_PROTECT2), 8'h01);
		check_allow("ram_wr", 16'h8123, 1'b1, 1'b1);
		check_allow("sram_wr", 16'h7FFF, 1'b1, 1'b1);
		check_allow("rom_wr", 16'hA000, 1'b1, 1'b0);
		check_allow("top_rom_wr", 16'hE000, 1'b1, 1'b0);
		check_allow("rom_rd", 16'hA000, 1'b0, 1'b1);
		check_allow("sram_rd", 16'h6000, 1'b0, 1'b1);
		check_allow("below_sram_rd", 16'h5FFF, 1'b0, 1'b0);

		// CHR mapping, upper bits latched with each bank
		for (int m = 0; m < 4; m++) begin
			r     = $random(seed);
			upper = r[1:0];
			cpu_write(reg_addr(`MMC5_REG_CHR_UPPER), {6'd0, upper});
			cpu_write(reg_addr(`MMC5_REG_CHR_MODE), {6'd0, m[1:0]});
			for (int i = 0; i < 8; i++) begin
				r = $random(seed);
				chr_banks[i] = {upper, r[7:0]};
				cpu_write(reg_addr(`MMC5_REG_CHR_BANK0 + 10'(i)), r[7:0]);
			end
			for (int k = 0; k < 8; k++) begin
				r = $random(seed);
				drive_chr({1'b0, r[12:0]});  // Pattern tables only
				check_chr($sformatf("chr_mode%0d_addr%h", m, chr_ain),
					exp_chr_addr(chr_ain, m[1:0], chr_banks), chr_aout);
			end
		end

		// Multiplier
		for (int k = 0; k < 4; k++) begin
			r = $random(seed);
			a = r[7:0];
			b = r[15:8];
			p = exp_product(a, b);
			cpu_write(reg_addr(`MMC5_REG_MUL_A), a);
			cpu_write(reg_addr(`MMC5_REG_MUL_B), b);
			cpu_read(reg_addr(`MMC5_REG_MUL_A), data);
			check_byte($sformatf("mul_lo_%h_%h", a, b), p[7:0], data);
			cpu_read(reg_addr(`MMC5_REG_MUL_B), data);
			check_byte($sformatf("mul_hi_%h_%h", a, b), p[15:8], data);
		end

		// ExRAM in modes 2, 3 and 0
		r = $random(seed);
		n = r[9:0];
		v = r[17:10];
		cpu_write(reg_addr(`MMC5_REG_EXRAM_MODE), 8'd2);
		cpu_write({`MMC5_EXRAM_BASE, n}, v);
		cpu_read({`MMC5_EXRAM_BASE, n}, data);
		check_byte("exram_mode2_rd", v, data);
		cpu_write(reg_addr(`MMC5_REG_EXRAM_MODE), 8'd3);
		cpu_write({`MMC5_EXRAM_BASE, n}, ~v);  // Read only, old byte stays
		cpu_read({`MMC5_EXRAM_BASE, n}, data);
		check_byte("exram_mode3_keep", v, data);
		cpu_write(reg_addr(`MMC5_REG_EXRAM_MODE), 8'd0);
		cpu_read({`MMC5_EXRAM_BASE, n}, data);
		check_byte("exram_mode0_rd", 8'hFF, data);

		// Scanline IRQ enabled
		r = $random(seed);
		t = r[7:0] % 8'd239 + 8'd1;  // Lines 1 to 239
		cpu_write(reg_addr(`MMC5_REG_IRQ_LINE), t);
		cpu_write(reg_addr(`MMC5_REG_IRQ_STATUS), 8'h80);
		rise = -1;
		for (int line = 0; line <= int'(t) + 4 && rise < 0; line++) begin
			ppu_step(line[8:0], 1'b1);
			if (irq)
				rise = line;
		end
		if (rise < 0) begin
			$display("Timeout: irq never rose within four lines past target line %0d", t);
			$display("Test failed");
			$fatal(1);
		end
		check_byte("irq_rise_line", t + 8'd1, rise[7:0]);  // First line after the target
		cpu_read(reg_addr(`MMC5_REG_IRQ_STATUS), data);
		check_byte("irq_status", 8'hFF, data);
		@(negedge clk);
		check_byte("irq_after_ack", 8'h00, {7'd0, irq});

		// Scanline IRQ disabled, pending still visible in status
		cpu_write(reg_addr(`MMC5_REG_IRQ_STATUS), 8'h00);
		ppu_step(9'd0, 1'b0);
		for (int line = 0; line <= int'(t) + 4; line++) begin
			ppu_step(line[8:0], 1'b1);
			check_byte($sformatf("irq_disabled_line%0d", line), 8'h00, {7'd0, irq});
		end
		cpu_read(reg_addr(`MMC5_REG_IRQ_STATUS), data);
		check_byte("pending_while_disabled", 8'hFF, data);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/chr_map.sv
// CHR physical address from the CHR mode and bank set A, combinational, used by mmc5_top
`timescale 1ns/1ps
`default_nettype none

module chr_map (
	input  mmc5_cpu_pkg::chr_mode_t       chr_mode,
	input  mmc5_ppu_pkg::chr_bank_t [7:0] chr_bank,
	input  logic [13:0]                   chr_ain,   // Pattern tables use bits 12:0
	output mmc5_ppu_pkg::chr_addr_t       chr_aout
);
	import mmc5_ppu_pkg::*;

	chr_bank_t sel;        // 1 kB page number
	logic [2:0] idx4;      // Register for the 4 kB half
	logic [2:0] idx2;      // Register for the 2 kB quarter

	assign idx4 = {chr_ain[12], 2'b11};      // Bank 3 or 7
	assign idx2 = {chr_ain[12:11], 1'b1};    // Bank 1, 3, 5 or 7

	// Larger pages drop the bank's low bits for address bits
	always_comb begin
		case (chr_mode)
			2'd0:    sel = {chr_bank[7][6:0], chr_ain[12:10]};    // 8 kB
			2'd1:    sel = {chr_bank[idx4][7:0], chr_ain[11:10]}; // 4 kB
			2'd2:    sel = {chr_bank[idx2][8:0], chr_ain[10]};    // 2 kB
			default: sel = chr_bank[chr_ain[12:10]];              // 1 kB
		endcase
	end

	// CHR ROM sits above PRG in the image
	assign chr_aout = {2'b10, sel, chr_ain[9:0]};

endmodule

`default_nettype wire

//--- src/exram.sv
// 1 kB expansion RAM on the CPU bus with mode-dependent access, instanced by mmc5_top
`timescale 1ns/1ps
`default_nettype none
`include "mmc5_params.svh"

module exram (
	input  logic                      clk,
	input  logic                      ce,
	input  logic [15:0]               prg_ain,
	input  logic [7:0]                prg_din,
	input  logic                      prg_write,
	input  mmc5_cpu_pkg::exram_mode_t exram_mode,
	input  logic                      ppu_in_frame,
	output logic [7:0]                exram_q,         // Byte at last cycle's address
	output logic                      exram_readable
);
	logic [7:0] mem [`MMC5_EXRAM_DEPTH];
	logic       win_sel;    // $5C00 to $5FFF
	logic       wr_en;
	logic [7:0] wr_data;

	assign win_sel = (prg_ain[15:10] == `MMC5_EXRAM_BASE);
	assign wr_en   = ce && prg_write && win_sel && (exram_mode != 2'd3);  // Mode 3 read only

	// Modes 0 and 1 store zero outside rendering
	assign wr_data = (exram_mode[1] || ppu_in_frame) ? prg_din : 8'h00;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[prg_ain[9:0]] <= wr_data;
		exram_q <= mem[prg_ain[9:0]];  // Read sees the old byte on a write edge
	end

	// CPU reads in modes 2 and 3
	assign exram_readable = exram_mode[1];

endmodule

`default_nettype wire

//--- src/mmc5_cpu_pkg.sv
// CPU side types for the MMC5 mapper, imported by the register file, PRG mapping and top level
`default_nettype none

package mmc5_cpu_pkg;

	// PRG banking mode
	// 0 one 32 kB bank
	// 1 two 16 kB banks
	// 2 16 kB then two 8 kB banks
	// 3 four 8 kB banks
	typedef logic [1:0] prg_mode_t;

	// CHR banking mode, 8/4/2/1 kB pages for modes 0 to 3
	typedef logic [1:0] chr_mode_t;

	// 8 kB PRG bank number
	// Bit 7 high selects ROM, low selects save RAM
	typedef logic [7:0] prg_bank_t;

	// Physical PRG address into the cartridge image
	typedef logic [21:0] prg_addr_t;

	// Expansion RAM mode
	// 0 and 1 write only while rendering
	// 2 plain read/write RAM
	// 3 read only
	typedef logic [1:0] exram_mode_t;

endpackage

`default_nettype wire

//--- src/mmc5_params.svh
// Address decode constants and reset values shared by the MMC5 mapper RTL and its testbench
`ifndef MMC5_PARAMS_SVH
`define MMC5_PARAMS_SVH

// Matched against prg_ain[15:10]
`define MMC5_REG_BASE        6'b010100   // $5000 to $53FF register block
`define MMC5_EXRAM_BASE      6'b010111   // $5C00 to $5FFF expansion RAM window

// Offsets inside the register block, matched against prg_ain[9:0]
`define MMC5_REG_PRG_MODE    10'h100
`define MMC5_REG_CHR_MODE    10'h101
`define MMC5_REG_PROTECT1    10'h102     // Write 2 to unlock
`define MMC5_REG_PROTECT2    10'h103     // Write 1 to unlock
`define MMC5_REG_EXRAM_MODE  10'h104
`define MMC5_REG_PRG_RAM     10'h113     // Bank for $6000 to $7FFF
`define MMC5_REG_PRG_BANK0   10'h114     // First of four, $5114 to $5117
`define MMC5_REG_CHR_BANK0   10'h120     // First of eight, $5120 to $5127
`define MMC5_REG_CHR_UPPER   10'h130     // Upper two CHR bank bits
`define MMC5_REG_IRQ_LINE    10'h203     // Target scanline
`define MMC5_REG_IRQ_STATUS  10'h204     // Enable on write, status on read
`define MMC5_REG_MUL_A       10'h205     // Operand A, product low on read
`define MMC5_REG_MUL_B       10'h206     // Operand B, product high on read

// Sizes and limits
`define MMC5_PRG_WINDOWS     4           // 8 kB CPU windows at $8000 and up
`define MMC5_EXRAM_DEPTH     1024
`define MMC5_LAST_VISIBLE    240         // Targets at or past this never fire

// Physical layout and reset state
`define MMC5_RAM_BASE_HI     6'b111100   // Save RAM sits at the top of PRG space
`define MMC5_RESET_PRG_BANK3 8'h7F       // Last ROM bank at $E000

`endif

//--- src/mmc5_ppu_pkg.sv
// PPU side types for the MMC5 mapper, imported by the CHR mapping, scanline IRQ and top level
`default_nettype none

package mmc5_ppu_pkg;

	// Scanline as reported by the PPU, 0 to 261
	typedef logic [8:0] scanline_t;

	// 1 kB CHR bank, top two bits come from $5130
	typedef logic [9:0] chr_bank_t;

	// Physical CHR address into the cartridge image
	typedef logic [21:0] chr_addr_t;

endpackage

`default_nettype wire

//--- src/mmc5_regs.sv
// MMC5 register file with write decode, multiplier and CPU read-back mux, instanced by mmc5_top
`timescale 1ns/1ps
`default_nettype none
`include "mmc5_params.svh"

module mmc5_regs (
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  logic                                              ce,           // CPU cycle strobe
	input  logic [15:0]                                       prg_ain,
	input  logic [7:0]                                        prg_din,
	input  logic                                              prg_write,
	input  logic                                              prg_read,
	input  logic                                              irq_pending,
	input  logic                                              ppu_in_frame,
	input  logic [7:0]                                        exram_q,      // Registered ExRAM byte
	input  logic                                              exram_readable,
	output mmc5_cpu_pkg::prg_mode_t                           prg_mode,
	output mmc5_cpu_pkg::chr_mode_t                           chr_mode,
	output mmc5_cpu_pkg::exram_mode_t                         exram_mode,
	output logic                                              ram_we,       // Both protect keys set
	output logic [2:0]                                        prg_ram_bank,
	output mmc5_cpu_pkg::prg_bank_t [`MMC5_PRG_WINDOWS-1:0]   prg_bank,
	output mmc5_ppu_pkg::chr_bank_t [7:0]                     chr_bank,
	output logic [7:0]                                        irq_target,
	output logic                                              irq_enable,
	output logic [7:0]                                        prg_dout
);
	import mmc5_ppu_pkg::*;

	logic       reg_sel;       // Address inside $5000 to $53FF
	logic       exram_sel;     // Address inside $5C00 to $5FFF
	logic       reg_wr;
	logic       protect1;
	logic       protect2;
	logic [1:0] chr_upper;     // Latched from $5130
	chr_bank_t  chr_bank_new;  // Value loaded into any CHR bank on write
	logic [7:0] mul_a;
	logic [7:0] mul_b;
	logic [15:0] product;

	assign reg_sel      = (prg_ain[15:10] == `MMC5_REG_BASE);
	assign exram_sel    = (prg_ain[15:10] == `MMC5_EXRAM_BASE);
	assign reg_wr       = ce && prg_write && reg_sel;
	assign chr_bank_new = {chr_upper, prg_din};
	assign ram_we       = protect1 && protect2;
	assign product      = mul_a * mul_b;  // 8x8 unsigned

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prg_mode     <= 2'd3;  // Four 8 kB windows
			chr_mode     <= 2'd0;
			exram_mode   <= 2'd0;
			protect1     <= 1'b0;
			protect2     <= 1'b0;
			prg_ram_bank <= 3'd0;
			prg_bank     <= '0;
			prg_bank[3]  <= `MMC5_RESET_PRG_BANK3;  // Boot from the last ROM bank
			chr_bank     <= '0;
			chr_upper    <= 2'd0;
			irq_target   <= 8'd0;
			irq_enable   <= 1'b0;
		end else if (reg_wr) begin
			case (prg_ain[9:0])
				`MMC5_REG_PRG_MODE:   prg_mode     <= prg_din[1:0];
				`MMC5_REG_CHR_MODE:   chr_mode     <= prg_din[1:0];
				`MMC5_REG_PROTECT1:   protect1     <= (prg_din[1:0] == 2'b10);
				`MMC5_REG_PROTECT2:   protect2     <= (prg_din[1:0] == 2'b01);
				`MMC5_REG_EXRAM_MODE: exram_mode   <= prg_din[1:0];
				`MMC5_REG_PRG_RAM:    prg_ram_bank <= prg_din[2:0];
				`MMC5_REG_CHR_UPPER:  chr_upper    <= prg_din[1:0];
				`MMC5_REG_IRQ_LINE:   irq_target   <= prg_din;
				`MMC5_REG_IRQ_STATUS: irq_enable   <= prg_din[7];
				default: begin
				end
			endcase
			// Bank groups decoded by their aligned base
			if ({prg_ain[9:2], 2'b00} == `MMC5_REG_PRG_BANK0)
				prg_bank[prg_ain[1:0]] <= prg_din;
			if ({prg_ain[9:3], 3'b000} == `MMC5_REG_CHR_BANK0)
				chr_bank[prg_ain[2:0]] <= chr_bank_new;  // Upper bits captured now
		end
	end

	// Multiplier operands
	always_ff @(posedge clk) begin
		if (reg_wr && prg_ain[9:0] == `MMC5_REG_MUL_A)
			mul_a <= prg_din;
		if (reg_wr && prg_ain[9:0] == `MMC5_REG_MUL_B)
			mul_b <= prg_din;
	end

	// Read-back, open bus reads as FF
	always_comb begin
		prg_dout = 8'hFF;
		if (prg_read) begin
			if (exram_sel && exram_readable) begin
				prg_dout = exram_q;  // Modes 2 and 3 only
			end else if (reg_sel) begin
				case (prg_ain[9:0])
					`MMC5_REG_IRQ_STATUS: prg_dout = {irq_pending, ppu_in_frame, 6'b111111};
					`MMC5_REG_MUL_A:      prg_dout = product[7:0];
					`MMC5_REG_MUL_B:      prg_dout = product[15:8];
					default:              prg_dout = 8'hFF;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- src/mmc5_top.sv
// MMC5 mapper top level tying the register file to PRG, CHR, IRQ and expansion RAM blocks
`timescale 1ns/1ps
`default_nettype none
`include "mmc5_params.svh"

module mmc5_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ce,
	input  logic [15:0]             prg_ain,
	input  logic [7:0]              prg_din,
	input  logic                    prg_read,
	input  logic                    prg_write,
	input  logic [13:0]             chr_ain,
	input  logic                    ppu_ce,
	input  logic                    ppu_in_frame,
	input  mmc5_ppu_pkg::scanline_t ppu_scanline,
	output mmc5_cpu_pkg::prg_addr_t prg_aout,
	output logic                    prg_allow,
	output logic [7:0]              prg_dout,
	output mmc5_ppu_pkg::chr_addr_t chr_aout,
	output logic                    irq
);
	import mmc5_cpu_pkg::*;
	import mmc5_ppu_pkg::*;

	prg_mode_t                             prg_mode;
	chr_mode_t                             chr_mode;
	exram_mode_t                           exram_mode;
	logic                                  ram_we;
	logic [2:0]                            prg_ram_bank;
	prg_bank_t [`MMC5_PRG_WINDOWS-1:0]     prg_bank;      // Raw $5114 to $5117
	prg_bank_t [`MMC5_PRG_WINDOWS-1:0]     window_bank;   // After mode decode
	chr_bank_t [7:0]                       chr_bank;
	logic [7:0]                            irq_target;
	logic                                  irq_enable;
	logic                                  irq_pending;
	logic [7:0]                            exram_q;
	logic                                  exram_readable;

	mmc5_regs u_regs (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.prg_ain(prg_ain), .prg_din(prg_din), .prg_write(prg_write), .prg_read(prg_read),
		.irq_pending(irq_pending), .ppu_in_frame(ppu_in_frame),
		.exram_q(exram_q), .exram_readable(exram_readable),
		.prg_mode(prg_mode), .chr_mode(chr_mode), .exram_mode(exram_mode),
		.ram_we(ram_we), .prg_ram_bank(prg_ram_bank), .prg_bank(prg_bank),
		.chr_bank(chr_bank), .irq_target(irq_target), .irq_enable(irq_enable),
		.prg_dout(prg_dout)
	);

	// One bank selector per 8 kB CPU window
	for (genvar w = 0; w < `MMC5_PRG_WINDOWS; w++) begin : g_window
		prg_window #(.WINDOW(w)) u_window (
			.prg_mode(prg_mode), .prg_bank(prg_bank), .bank(window_bank[w])
		);
	end

	prg_map u_prg_map (
		.prg_ain(prg_ain), .prg_write(prg_write), .window_bank(window_bank),
		.prg_ram_bank(prg_ram_bank), .ram_we(ram_we),
		.prg_aout(prg_aout), .prg_allow(prg_allow)
	);

	chr_map u_chr_map (
		.chr_mode(chr_mode), .chr_bank(chr_bank), .chr_ain(chr_ain), .chr_aout(chr_aout)
	);

	scanline_irq u_irq (
		.clk(clk), .rst_n(rst_n), .ce(ce), .ppu_ce(ppu_ce),
		.prg_ain(prg_ain), .prg_read(prg_read), .ppu_in_frame(ppu_in_frame),
		.ppu_scanline(ppu_scanline), .irq_target(irq_target), .irq_enable(irq_enable),
		.irq_pending(irq_pending), .irq(irq)
	);

	exram u_exram (
		.clk(clk), .ce(ce), .prg_ain(prg_ain), .prg_din(prg_din), .prg_write(prg_write),
		.exram_mode(exram_mode), .ppu_in_frame(ppu_in_frame),
		.exram_q(exram_q), .exram_readable(exram_readable)
	);

endmodule

`default_nettype wire

//--- src/prg_map.sv
// PRG physical address and access permission from the window banks, used by mmc5_top
`timescale 1ns/1ps
`default_nettype none
`include "mmc5_params.svh"

module prg_map (
	input  logic [15:0]                                     prg_ain,
	input  logic                                            prg_write,
	input  mmc5_cpu_pkg::prg_bank_t [`MMC5_PRG_WINDOWS-1:0] window_bank,
	input  logic [2:0]                                      prg_ram_bank,
	input  logic                                            ram_we,       // Protect keys unlocked
	output mmc5_cpu_pkg::prg_addr_t                         prg_aout,
	output logic                                            prg_allow
);
	import mmc5_cpu_pkg::*;

	prg_bank_t sel;      // Bank serving this address
	logic      mapped;   // $6000 and up
	logic      is_rom;

	// $6000 to $7FFF always goes to the RAM bank
	assign sel    = prg_ain[15] ? window_bank[prg_ain[14:13]] : {5'b00000, prg_ram_bank};
	assign mapped = prg_ain[15] || (prg_ain[14:13] == 2'b11);
	assign is_rom = sel[7];

	// ROM lives low, save RAM at the top of the space
	assign prg_aout = is_rom ? {2'b00, sel[6:0], prg_ain[12:0]}
	                         : {`MMC5_RAM_BASE_HI, sel[2:0], prg_ain[12:0]};

	// Reads always pass, writes only to unlocked RAM
	assign prg_allow = mapped && (!prg_write || (!is_rom && ram_we));

endmodule

`default_nettype wire

//--- src/prg_window.sv
// Bank selection for one 8 kB CPU window, one instance per window under mmc5_top
`timescale 1ns/1ps
`default_nettype none
`include "mmc5_params.svh"

module prg_window #(
	parameter int WINDOW = 0  // 0 $8000, 1 $A000, 2 $C000, 3 $E000
) (
	input  mmc5_cpu_pkg::prg_mode_t                         prg_mode,
	input  mmc5_cpu_pkg::prg_bank_t [`MMC5_PRG_WINDOWS-1:0] prg_bank,
	output mmc5_cpu_pkg::prg_bank_t                         bank
);
	import mmc5_cpu_pkg::*;

	localparam logic [1:0] WIN = 2'(WINDOW);

	prg_bank_t bank3;   // $5117 always maps ROM
	prg_bank_t half;    // Source of the 16 kB half this window sits in
	prg_bank_t bank16;

	assign bank3  = {1'b1, prg_bank[3][6:0]};
	assign half   = WIN[1] ? bank3 : prg_bank[1];
	assign bank16 = {half[7:1], WIN[0]};  // Low bit picks the 8 kB page

	always_comb begin
		case (prg_mode)
			2'd0:    bank = {bank3[7:2], WIN};                   // 32 kB from bank 3
			2'd1:    bank = bank16;                              // 16 kB + 16 kB
			2'd2:    bank = WIN[1] ? (WIN[0] ? bank3 : prg_bank[2]) : bank16;
			default: bank = (WIN == 2'd3) ? bank3 : prg_bank[WIN]; // Plain 8 kB
		endcase
	end

endmodule

`default_nettype wire

//--- src/scanline_irq.sv
// Scanline match IRQ with pending flag cleared by a $5204 read, instanced by mmc5_top
`timescale 1ns/1ps
`default_nettype none
`include "mmc5_params.svh"

module scanline_irq (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ce,
	input  logic                    ppu_ce,        // PPU dot strobe
	input  logic [15:0]             prg_ain,
	input  logic                    prg_read,
	input  logic                    ppu_in_frame,
	input  mmc5_ppu_pkg::scanline_t ppu_scanline,
	input  logic [7:0]              irq_target,
	input  logic                    irq_enable,
	output logic                    irq_pending,
	output logic                    irq
);
	import mmc5_ppu_pkg::*;

	scanline_t target_line;
	logic      target_ok;    // Non-zero and visible
	logic      irq_trig;     // PPU was on the target line at the last strobe
	logic      last_low;     // Scanline bit 0 at the last strobe
	logic      status_rd;
	logic      line_step;

	assign target_line = {1'b0, irq_target};
	assign target_ok   = (irq_target != 8'd0) && (target_line < `MMC5_LAST_VISIBLE);
	assign status_rd   = ce && prg_read && (prg_ain == {`MMC5_REG_BASE, `MMC5_REG_IRQ_STATUS});
	assign line_step   = ppu_scanline[0] != last_low;  // Scanline just advanced

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_trig    <= 1'b0;
			last_low    <= 1'b0;
			irq_pending <= 1'b0;
		end else begin
			if (ppu_ce) begin
				irq_trig <= target_ok && (ppu_scanline == target_line);
				last_low <= ppu_scanline[0];
			end
			if (status_rd || (ppu_ce && !ppu_in_frame))
				irq_pending <= 1'b0;  // Acknowledge or vblank
			else if (ppu_ce && line_step && irq_trig)
				irq_pending <= 1'b1;  // First strobe past the target line
		end
	end

	assign irq = irq_pending && irq_enable;

endmodule

`default_nettype wire
